// File: si_monitor_pkg.sv
`default_nettype none

package si_monitor_pkg;

    // Lane count and derived widths
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = $clog2(NUM_LANES);

    // Nominal PAM4 level amplitudes in mV
    localparam logic [7:0] LEVEL_AMP_0 = 8'd25;
    localparam logic [7:0] LEVEL_AMP_1 = 8'd75;
    localparam logic [7:0] LEVEL_AMP_2 = 8'd125;
    localparam logic [7:0] LEVEL_AMP_3 = 8'd175;

    // Eye and crosstalk thresholds
    localparam logic [7:0] CLOSURE_MARGIN  = 8'd20;  // Margin below this is a closure
    localparam logic [7:0] COUPLING_SIG    = 8'd20;  // Active aggressor above this
    localparam logic [9:0] CRIT_ENERGY     = 10'd100;
    localparam logic [2:0] CRIT_AGGRESSORS = 3'd2;
    localparam logic [7:0] ERROR_CLOSURES  = 8'd10;  // Issue lane above this

    // Record buffer sizing
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // One 2-bit PAM4 symbol per lane
    typedef logic [NUM_LANES-1:0][1:0] pam4_lanes_t;

    // Per-lane measurement from one sample
    typedef struct packed {
        logic [7:0] margin;      // Eye voltage margin, mV
        logic [9:0] energy;      // Summed coupling strength
        logic [2:0] aggressors;  // Count of significant couplers
    } lane_meas_t;

    typedef lane_meas_t [NUM_LANES-1:0] si_record_t;

    // Running statistics for one lane
    typedef struct packed {
        logic [7:0] min_height;
        logic [7:0] max_height;
        logic [7:0] closure_events;  // Saturates at 255
        logic       critical;        // Sticky
    } lane_stat_t;

    typedef lane_stat_t [NUM_LANES-1:0] stats_bus_t;

    // Code to amplitude lookup
    function automatic logic [7:0] level_amp(input logic [1:0] code);
        logic [7:0] amp;
        case (code)
            2'd0:    amp = LEVEL_AMP_0;
            2'd1:    amp = LEVEL_AMP_1;
            2'd2:    amp = LEVEL_AMP_2;
            default: amp = LEVEL_AMP_3;
        endcase
        return amp;
    endfunction

    // Unsigned absolute difference
    function automatic logic [7:0] abs_diff(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] d;
        if (a > b) begin
            d = a - b;
        end else begin
            d = b - a;
        end
        return d;
    endfunction

endpackage

`default_nettype wire

// File: symbol_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module symbol_sampler (
    input  logic                       clk_management,
    input  logic                       rst_n,
    input  logic                       sample_valid,
    input  logic                       monitor_enable,
    input  si_monitor_pkg::pam4_lanes_t pam4_signal,
    input  si_monitor_pkg::pam4_lanes_t pam4_recovered,
    output logic                       rec_push,
    output si_monitor_pkg::si_record_t rec
);

    logic                       accept;
    logic [7:0]                 raw_amp [si_monitor_pkg::NUM_LANES];
    logic [7:0]                 rcv_amp [si_monitor_pkg::NUM_LANES];
    si_monitor_pkg::si_record_t rec_next;

    assign accept = sample_valid && monitor_enable;  // Gated by enable

    // Amplitude of each raw and recovered symbol
    always_comb begin
        for (int l = 0; l < si_monitor_pkg::NUM_LANES; l++) begin
            raw_amp[l] = si_monitor_pkg::level_amp(pam4_signal[l]);
            rcv_amp[l] = si_monitor_pkg::level_amp(pam4_recovered[l]);
        end
    end

    // Margin and crosstalk per victim lane
    always_comb begin
        for (int v = 0; v < si_monitor_pkg::NUM_LANES; v++) begin
            rec_next[v].margin     = si_monitor_pkg::abs_diff(raw_amp[v], rcv_amp[v]);
            rec_next[v].energy     = '0;
            rec_next[v].aggressors = '0;
            // Aggressors within two lanes on either side
            for (int a = 0; a < si_monitor_pkg::NUM_LANES; a++) begin
                if (a != v && a >= v - 2 && a <= v + 2) begin
                    rec_next[v].energy = rec_next[v].energy
                        + 10'(si_monitor_pkg::abs_diff(raw_amp[a], raw_amp[v]));
                    if (si_monitor_pkg::abs_diff(raw_amp[a], raw_amp[v])
                            > si_monitor_pkg::COUPLING_SIG) begin
                        rec_next[v].aggressors = rec_next[v].aggressors + 3'd1;
                    end
                end
            end
        end
    end

    // Push strobe one cycle after acceptance
    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            rec_push <= 1'b0;
        end else begin
            rec_push <= accept;
        end
    end

    // Record payload
    always_ff @(posedge clk_management) begin
        if (accept) begin
            rec <= rec_next;
        end
    end

endmodule

`default_nettype wire

// File: sample_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sample_fifo (
    input  logic                       clk_management,
    input  logic                       rst_n,
    input  logic                       rec_push,
    input  si_monitor_pkg::si_record_t rec,
    input  logic                       rec_pop,
    output si_monitor_pkg::si_record_t rd_rec,
    output logic                       fifo_empty,
    output logic [15:0]                dropped_count
);

    localparam int AW = si_monitor_pkg::FIFO_AW;

    si_monitor_pkg::si_record_t mem [si_monitor_pkg::FIFO_DEPTH];
    logic [AW-1:0]              wr_ptr;
    logic [AW-1:0]              rd_ptr;
    logic [AW:0]                count;
    logic                       full;
    logic                       do_push;
    logic                       do_pop;

    assign full       = (count == (AW+1)'(si_monitor_pkg::FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign do_push    = rec_push && !full;  // Full check ignores same-cycle pop
    assign do_pop     = rec_pop && !fifo_empty;
    assign rd_rec     = mem[rd_ptr];        // Head record, read asynchronously

    // Pointers, occupancy and drop counter
    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            dropped_count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(si_monitor_pkg::FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(si_monitor_pkg::FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (rec_push && full) begin
                dropped_count <= dropped_count + 16'd1;  // Wraps
            end
        end
    end

    // Storage
    always_ff @(posedge clk_management) begin
        if (do_push) begin
            mem[wr_ptr] <= rec;
        end
    end

endmodule

`default_nettype wire

// File: lane_stats.sv
`timescale 1ns/1ns
`default_nettype none

module lane_stats (
    input  logic                       clk_management,
    input  logic                       rst_n,
    input  si_monitor_pkg::si_record_t rd_rec,
    input  logic                       fifo_empty,
    output logic                       rec_pop,
    output si_monitor_pkg::stats_bus_t stats,
    output logic [15:0]                processed_count,
    output logic [2:0]                 error_count,
    output logic                       analysis_busy
);

    localparam int LW = si_monitor_pkg::LANE_W;

    logic                       active;    // Walking a latched record
    logic [LW-1:0]              lane_idx;
    logic                       last_lane;
    si_monitor_pkg::si_record_t cur_rec;
    si_monitor_pkg::lane_meas_t cur_meas;
    si_monitor_pkg::lane_stat_t cur_stat;
    si_monitor_pkg::lane_stat_t upd_stat;

    assign rec_pop       = !active && !fifo_empty;
    assign analysis_busy = !fifo_empty || active;
    assign last_lane     = (lane_idx == LW'(si_monitor_pkg::NUM_LANES - 1));

    // Shared update path, one lane at a time
    assign cur_meas = cur_rec[lane_idx];
    assign cur_stat = stats[lane_idx];

    always_comb begin
        upd_stat = cur_stat;
        if (cur_meas.margin < cur_stat.min_height) begin
            upd_stat.min_height = cur_meas.margin;
        end
        if (cur_meas.margin > cur_stat.max_height) begin
            upd_stat.max_height = cur_meas.margin;
        end
        if (cur_meas.margin < si_monitor_pkg::CLOSURE_MARGIN
                && cur_stat.closure_events != 8'hFF) begin
            upd_stat.closure_events = cur_stat.closure_events + 8'd1;  // Saturating
        end
        if (cur_meas.energy > si_monitor_pkg::CRIT_ENERGY
                || cur_meas.aggressors > si_monitor_pkg::CRIT_AGGRESSORS) begin
            upd_stat.critical = 1'b1;  // Sticky
        end
    end

    // Sequencer and processed counter
    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            active          <= 1'b0;
            lane_idx        <= '0;
            processed_count <= '0;
        end else if (active) begin
            lane_idx <= lane_idx + 1'b1;
            if (last_lane) begin
                active          <= 1'b0;
                lane_idx        <= '0;
                processed_count <= processed_count + 16'd1;
            end
        end else if (rec_pop) begin
            active <= 1'b1;
        end
    end

    // Latch head record on pop
    always_ff @(posedge clk_management) begin
        if (rec_pop) begin
            cur_rec <= rd_rec;
        end
    end

    // Per-lane statistics
    always_ff @(posedge clk_management or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < si_monitor_pkg::NUM_LANES; l++) begin
                stats[l].min_height     <= 8'hFF;
                stats[l].max_height     <= 8'h00;
                stats[l].closure_events <= 8'h00;
                stats[l].critical       <= 1'b0;
            end
        end else if (active) begin
            stats[lane_idx] <= upd_stat;
        end
    end

    // Issue lanes: many closures or crosstalk critical
    always_comb begin
        error_count = '0;
        for (int l = 0; l < si_monitor_pkg::NUM_LANES; l++) begin
            if (stats[l].closure_events > si_monitor_pkg::ERROR_CLOSURES
                    || stats[l].critical) begin
                error_count = error_count + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: si_monitor_top.sv
`timescale 1ns/1ns
`default_nettype none

module si_monitor_top (
    input  logic                        clk_management,
    input  logic                        rst_n,
    input  logic                        sample_valid,
    input  logic                        monitor_enable,
    input  si_monitor_pkg::pam4_lanes_t pam4_signal,
    input  si_monitor_pkg::pam4_lanes_t pam4_recovered,
    output si_monitor_pkg::stats_bus_t  stats,
    output logic [15:0]                 processed_count,
    output logic [15:0]                 dropped_count,
    output logic [2:0]                  error_count,
    output logic                        analysis_busy
);

    logic                       rec_push;
    si_monitor_pkg::si_record_t rec;
    si_monitor_pkg::si_record_t rd_rec;
    logic                       fifo_empty;
    logic                       rec_pop;

    // Producer
    symbol_sampler u_sampler (
        .clk_management (clk_management),
        .rst_n          (rst_n),
        .sample_valid   (sample_valid),
        .monitor_enable (monitor_enable),
        .pam4_signal    (pam4_signal),
        .pam4_recovered (pam4_recovered),
        .rec_push       (rec_push),
        .rec            (rec)
    );

    // Record buffer, drops when full
    sample_fifo u_fifo (
        .clk_management (clk_management),
        .rst_n          (rst_n),
        .rec_push       (rec_push),
        .rec            (rec),
        .rec_pop        (rec_pop),
        .rd_rec         (rd_rec),
        .fifo_empty     (fifo_empty),
        .dropped_count  (dropped_count)
    );

    // Consumer
    lane_stats u_stats (
        .clk_management  (clk_management),
        .rst_n           (rst_n),
        .rd_rec          (rd_rec),
        .fifo_empty      (fifo_empty),
        .rec_pop         (rec_pop),
        .stats           (stats),
        .processed_count (processed_count),
        .error_count     (error_count),
        .analysis_busy   (analysis_busy)
    );

endmodule

`default_nettype wire

// File: tb_si_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_si_monitor;

    logic                        clk_management;
    logic                        rst_n;
    logic                        sample_valid;
    logic                        monitor_enable;
    si_monitor_pkg::pam4_lanes_t pam4_signal;
    si_monitor_pkg::pam4_lanes_t pam4_recovered;
    si_monitor_pkg::stats_bus_t  stats;
    logic [15:0]                 processed_count;
    logic [15:0]                 dropped_count;
    logic [2:0]                  error_count;
    logic                        analysis_busy;

    // Parsed case lines with one entry per line
    logic [7:0] cmd_q[$];
    int         arg_a[$];
    int         arg_b[$];
    int         arg_c[$];
    int         arg_d[$];
    int         arg_e[$];

    // Reference model
    int exp_min[4];
    int exp_max[4];
    int exp_clos[4];
    bit exp_crit[4];
    int exp_proc;
    bit proc_exact;  // Cleared by a burst

    logic [31:0] lfsr_state = 32'he9dfdd7a;
    int errors             = 0;
    int errors_before_test = 0;
    int checks             = 0;
    int tests              = 0;
    int cycle_count        = 0;
    int cycle_limit        = 0;

    si_monitor_top u_dut (
        .clk_management  (clk_management),
        .rst_n           (rst_n),
        .sample_valid    (sample_valid),
        .monitor_enable  (monitor_enable),
        .pam4_signal     (pam4_signal),
        .pam4_recovered  (pam4_recovered),
        .stats           (stats),
        .processed_count (processed_count),
        .dropped_count   (dropped_count),
        .error_count     (error_count),
        .analysis_busy   (analysis_busy)
    );

    initial begin
        clk_management = 1'b0;
        forever #5 clk_management = ~clk_management;
    end

    always @(posedge clk_management) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic wait_cycle();
        @(posedge clk_management);
        #1;  // Drive and sample away from the edge
    endtask

    task automatic check_val(input string what, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // PAM4 levels sit 50 mV apart from 25 mV
    function automatic int amp_of(input logic [1:0] code);
        return 25 + 50 * int'(code);
    endfunction

    function automatic void reset_model();
        for (int l = 0; l < 4; l++) begin
            exp_min[l]  = 255;
            exp_max[l]  = 0;
            exp_clos[l] = 0;
            exp_crit[l] = 1'b0;
        end
        exp_proc   = 0;
        proc_exact = 1'b1;
    endfunction

    function automatic void apply_sample(input logic [7:0] raw, input logic [7:0] rcv);
        int margin;
        int energy;
        int aggr;
        int diff;
        for (int v = 0; v < 4; v++) begin
            margin = amp_of(raw[2*v +: 2]) - amp_of(rcv[2*v +: 2]);
            if (margin < 0) begin
                margin = -margin;
            end
            energy = 0;
            aggr   = 0;
            for (int a = 0; a < 4; a++) begin
                if (a != v && a - v <= 2 && v - a <= 2) begin
                    diff = amp_of(raw[2*a +: 2]) - amp_of(raw[2*v +: 2]);
                    if (diff < 0) begin
                        diff = -diff;
                    end
                    energy = energy + diff;
                    if (diff > 20) begin
                        aggr++;
                    end
                end
            end
            if (margin < exp_min[v]) begin
                exp_min[v] = margin;
            end
            if (margin > exp_max[v]) begin
                exp_max[v] = margin;
            end
            if (margin < 20 && exp_clos[v] < 255) begin
                exp_clos[v]++;
            end
            if (energy > 100 || aggr > 2) begin
                exp_crit[v] = 1'b1;  // Sticky
            end
        end
    endfunction

    // Cycle budget from sample counts and gaps
    function automatic int limit_from_cases();
        int total;
        total = 100;
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "s":     total = total + arg_d[i] * arg_e[i] + 1;
                "n":     total = total + arg_a[i] * arg_b[i] + 1;
                "b":     total = total + arg_a[i] + 2;
                "r":     total = total + 6;
                default: total = total + 60;  // Drain of a full FIFO
            endcase
        end
        return total;
    endfunction

    task automatic drive_one(input logic [7:0] raw, input logic [7:0] rcv, input bit en,
                             input int gap);
        pam4_signal    = raw;
        pam4_recovered = rcv;
        monitor_enable = en;
        sample_valid   = 1'b1;
        wait_cycle();
        sample_valid = 1'b0;
        wait_cycle();
        // An accepted sample sits in the FIFO by now
        check_val("analysis_busy after sample", int'(analysis_busy), int'(en));
        repeat (gap - 2) wait_cycle();
    endtask

    task automatic do_reset();
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        repeat (4) wait_cycle();
        rst_n = 1'b1;
        wait_cycle();
        reset_model();
    endtask

    task automatic spaced_samples(input logic [7:0] raw, input logic [7:0] rcv, input bit en,
                                  input int gap, input int count);
        for (int k = 0; k < count; k++) begin
            drive_one(raw, rcv, en, gap);
            if (en) begin
                apply_sample(raw, rcv);
                exp_proc++;
            end
        end
    endtask

    task automatic random_samples(input int count, input int gap);
        logic [7:0] raw;
        logic [7:0] rcv;
        for (int k = 0; k < count; k++) begin
            raw = rand_byte();
            rcv = rand_byte();
            drive_one(raw, rcv, 1'b1, gap);
            apply_sample(raw, rcv);
            exp_proc++;
        end
    endtask

    task automatic burst_samples(input int count, input logic [7:0] raw, input logic [7:0] rcv);
        pam4_signal    = raw;
        pam4_recovered = rcv;
        monitor_enable = 1'b1;
        sample_valid   = 1'b1;
        repeat (count) wait_cycle();
        sample_valid = 1'b0;
        // Identical records so one update stands for all kept ones
        if (count > 0) begin
            apply_sample(raw, rcv);
        end
        proc_exact = 1'b0;
    endtask

    task automatic compare_stats(input int total, input int drop_min, input int drop_max);
        int exp_err;
        int dropped;
        repeat (3) wait_cycle();
        while (analysis_busy) wait_cycle();
        exp_err = 0;
        for (int l = 0; l < 4; l++) begin
            check_val($sformatf("lane %0d min_height", l), int'(stats[l].min_height), exp_min[l]);
            check_val($sformatf("lane %0d max_height", l), int'(stats[l].max_height), exp_max[l]);
            check_val($sformatf("lane %0d closure_events", l),
                      int'(stats[l].closure_events), exp_clos[l]);
            check_val($sformatf("lane %0d critical", l), int'(stats[l].critical),
                      int'(exp_crit[l]));
            if (exp_clos[l] > 10 || exp_crit[l]) begin
                exp_err++;
            end
        end
        check_val("error_count", int'(error_count), exp_err);
        if (proc_exact) begin
            check_val("processed_count", int'(processed_count), exp_proc);
        end
        check_val("processed plus dropped", int'(processed_count) + int'(dropped_count), total);
        dropped = int'(dropped_count);
        check_val($sformatf("dropped_count %0d within %0d..%0d", dropped, drop_min, drop_max),
                  (dropped >= drop_min && dropped <= drop_max) ? 1 : 0, 1);
        tests++;
        $display("test %0d %s, %0d errors", tests,
                 (errors == errors_before_test) ? "ok" : "failed",
                 errors - errors_before_test);
        errors_before_test = errors;
    endtask

    initial begin
        int         fd;
        int         nf;
        int         need;
        string      line;
        logic [7:0] kind;
        int         a;
        int         b;
        int         c;
        int         d;
        int         e;

        rst_n          = 1'b0;
        sample_valid   = 1'b0;
        monitor_enable = 1'b0;
        pam4_signal    = '0;
        pam4_recovered = '0;

        fd = $fopen("si_monitor_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open si_monitor_cases.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = line.getc(0);
                a    = 0;
                b    = 0;
                c    = 0;
                d    = 0;
                e    = 0;
                nf   = 0;
                case (kind)
                    "s": begin
                        need = 5;
                        nf   = $sscanf(line, "s %h %h %d %d %d", a, b, c, d, e);
                    end
                    "b": begin
                        need = 3;
                        nf   = $sscanf(line, "b %d %h %h", a, b, c);
                    end
                    "n": begin
                        need = 2;
                        nf   = $sscanf(line, "n %d %d", a, b);
                    end
                    "c": begin
                        need = 3;
                        nf   = $sscanf(line, "c %d %d %d", a, b, c);
                    end
                    "r":                        need = 0;
                    "#", " ", 8'd10, 8'd13, 8'd0: need = -1;  // Comment or blank
                    default: begin
                        $display("unknown line in cases file: %s", line);
                        errors++;
                        need = -1;
                    end
                endcase
                if (need >= 0 && nf != need) begin
                    $display("malformed line in cases file: %s", line);
                    errors++;
                end else if (need >= 0) begin
                    cmd_q.push_back(kind);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    arg_c.push_back(c);
                    arg_d.push_back(d);
                    arg_e.push_back(e);
                end
            end
            $fclose(fd);
        end

        cycle_limit = limit_from_cases();
        do_reset();
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "r": do_reset();
                "s": spaced_samples(8'(arg_a[i]), 8'(arg_b[i]), arg_c[i] != 0,
                                    arg_d[i], arg_e[i]);
                "b": burst_samples(arg_a[i], 8'(arg_b[i]), 8'(arg_c[i]));
                "n": random_samples(arg_a[i], arg_b[i]);
                default: compare_stats(arg_a[i], arg_b[i], arg_c[i]);
            endcase
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: si_monitor_cases.txt
# r = reset | s raw rcv en gap repeat | b count raw rcv | n count gap | c total drop_min drop_max
# raw and rcv are hex lane codes with lane 0 in bits 1:0; total is processed plus dropped
# Eye margin: matched codes, one level apart, full swing
r
s e4 e4 1 6 1
s e4 b9 1 6 1
s 00 ff 1 6 1
c 3 0 0
# Issue lane: ten closures on lane 0 are not enough, eleven are
r
s 00 54 1 6 10
c 10 0 0
s 00 54 1 6 1
c 11 0 0
# Closure count saturates on a long run
r
s 00 00 1 6 260
c 260 0 0
# Crosstalk: lane 1 alone at level 1, then quiet samples
r
s 04 59 1 6 1
c 1 0 0
s 00 55 1 6 4
c 5 0 0
# Lane 3 at level 3 reaches lanes 1 and 2 only
s c0 95 1 7 1
s 00 55 1 6 2
c 8 0 0
# Gating: nothing counts with enable low
r
s e4 e4 0 6 5
s 0c 00 0 8 3
c 0 0 0
s 0c 0c 1 6 1
s e4 e4 0 6 2
c 1 0 0
# Overflow: back-to-back burst into the FIFO
r
b 20 00 55
c 20 1 19
# Random spaced samples
r
n 40 6
c 40 0 0
n 30 9
c 70 0 0

// File: files.f
si_monitor_pkg.sv
symbol_sampler.sv
sample_fifo.sv
lane_stats.sv
si_monitor_top.sv
tb_si_monitor.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_si_monitor
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
